// ==== Makefile ====
OBJ_DIR = obj_dir
LOG = sim.log

all: run

run: $(OBJ_DIR)/Vtb_delay_calc
	./$(OBJ_DIR)/Vtb_delay_calc | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

$(OBJ_DIR)/Vtb_delay_calc: project.f *.sv
	verilator --binary --timing --assert -f project.f --top-module tb_delay_calc --Mdir $(OBJ_DIR)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module tb_delay_calc

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all run lint clean

// ==== burst_slot_table.sv ====
`timescale 1ns/1ps

module burst_slot_table #(
  parameter int unsigned NumSlots = 4,
  parameter type iid_t = logic [2:0],
  parameter bit TracksData = 1'b1
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Burst intake
  input  logic                                      i_valid,
  output logic                                      o_ready,
  input  iid_t                                      i_iid,
  input  logic [delay_calc_pkg::AddrWidth-1:0]      i_addr,
  input  logic [delay_calc_pkg::BurstLenWidth-1:0]  i_len,
  input  logic [delay_calc_pkg::BurstSizeWidth-1:0] i_size,
  input  logic [delay_calc_pkg::BurstLenWidth:0]    i_data_cnt,

  // Data beats arriving after the address
  input  logic i_data_valid,
  output logic o_data_ready,

  // Beat offered to the scheduler
  output logic                                 o_cand_valid,
  output logic [delay_calc_pkg::AddrWidth-1:0] o_cand_addr,

  input  logic i_issue,
  input  logic i_done,

  output logic [2**$bits(iid_t)-1:0] o_release_en,
  input  logic [2**$bits(iid_t)-1:0] i_released_onehot
);

  import delay_calc_pkg::*;

  localparam int unsigned NumIids = 2 ** $bits(iid_t);
  localparam int unsigned SeqWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1;

  logic [NumSlots-1:0]    valid_q;
  logic [NumSlots-1:0]    valid_d;
  logic [SeqWidth-1:0]    seq_q [NumSlots];
  logic [SeqWidth-1:0]    seq_d [NumSlots];
  logic [MaxBurstLen-1:0] present_q [NumSlots];
  logic [MaxBurstLen-1:0] present_d [NumSlots];
  logic [MaxBurstLen-1:0] issued_q [NumSlots];
  logic [MaxBurstLen-1:0] issued_d [NumSlots];
  logic [MaxBurstLen-1:0] done_q [NumSlots];
  logic [MaxBurstLen-1:0] done_d [NumSlots];
  logic [NumIids-1:0]     release_q;
  logic [NumIids-1:0]     release_d;

  // Burst payload, only meaningful while the slot is valid
  iid_t                      iid_q [NumSlots];
  logic [AddrWidth-1:0]      base_q [NumSlots];
  logic [BurstSizeWidth-1:0] size_q [NumSlots];

  logic [NumSlots-1:0]      alloc_oh;
  logic                     accept;
  logic [NumSlots-1:0]      retire;
  logic [NumSlots-1:0]      lacks_data;
  logic [NumSlots-1:0]      data_oh;
  logic                     data_fire;
  logic [MaxBurstLen-1:0]   avail [NumSlots];
  logic [MaxBurstLen-1:0]   beat_oh [NumSlots];
  logic [BurstLenWidth-1:0] beat_idx [NumSlots];
  logic [AddrWidth-1:0]     beat_addr [NumSlots];
  logic [NumSlots-1:0]      has_avail;
  logic [NumSlots-1:0]      cand_oh;

  // Lowest sequence number wins; sequence numbers stay dense from zero
  function automatic logic [NumSlots-1:0] pick_oldest(
      input logic [NumSlots-1:0] mask,
      input logic [SeqWidth-1:0] seq [NumSlots]);
    logic [NumSlots-1:0] pick;
    logic [SeqWidth-1:0] best;
    pick = '0;
    best = '1;
    for (int s = 0; s < NumSlots; s++) begin
      if (mask[s] && (pick == '0 || seq[s] < best)) begin
        pick = '0;
        pick[s] = 1'b1;
        best = seq[s];
      end
    end
    return pick;
  endfunction

  // Lowest free slot takes the next burst
  assign alloc_oh = ~valid_q & (valid_q + 1'b1);
  assign o_ready  = ~&valid_q;
  assign accept   = i_valid && o_ready;

  always_comb begin
    for (int s = 0; s < NumSlots; s++) begin
      retire[s]     = valid_q[s] && &done_q[s];
      lacks_data[s] = valid_q[s] && !(&present_q[s]);
      avail[s]      = valid_q[s] ? (present_q[s] & ~issued_q[s] & ~done_q[s]) : '0;
      has_avail[s]  = |avail[s];
      beat_oh[s]    = avail[s] & (~avail[s] + 1'b1);
      beat_idx[s]   = '0;
      for (int b = MaxBurstLen - 1; b >= 0; b--) begin
        if (avail[s][b]) begin
          beat_idx[s] = BurstLenWidth'(b);
        end
      end
      beat_addr[s] = base_q[s] + (AddrWidth'(beat_idx[s]) << size_q[s]);
    end
  end

  // Write data fills the oldest burst still missing beats
  assign data_oh      = pick_oldest(lacks_data, seq_q);
  assign o_data_ready = |data_oh;
  assign data_fire    = i_data_valid && o_data_ready;

  assign cand_oh      = pick_oldest(has_avail, seq_q);
  assign o_cand_valid = |cand_oh;

  always_comb begin
    o_cand_addr = '0;
    for (int s = 0; s < NumSlots; s++) begin
      if (cand_oh[s]) begin
        o_cand_addr = beat_addr[s];
      end
    end
  end

  always_comb begin
    logic [SeqWidth-1:0] live_cnt;
    live_cnt  = '0;
    release_d = release_q & ~i_released_onehot;
    for (int s = 0; s < NumSlots; s++) begin
      if (valid_q[s] && !retire[s]) begin
        live_cnt = live_cnt + 1'b1;
      end
    end
    for (int s = 0; s < NumSlots; s++) begin
      valid_d[s]   = valid_q[s] && !retire[s];
      seq_d[s]     = seq_q[s];
      present_d[s] = present_q[s];
      issued_d[s]  = issued_q[s];
      done_d[s]    = done_q[s];
      if (retire[s]) begin
        release_d[iid_q[s]] = 1'b1;
      end
      // Close the gap left by a retiring older slot
      for (int j = 0; j < NumSlots; j++) begin
        if (retire[j] && seq_q[j] < seq_q[s]) begin
          seq_d[s] = seq_d[s] - 1'b1;
        end
      end
      if (data_fire && data_oh[s]) begin
        present_d[s] = present_q[s] | (~present_q[s] & (present_q[s] + 1'b1));
      end
      if (i_issue && cand_oh[s]) begin
        issued_d[s] = issued_q[s] | beat_oh[s];
      end
      // Only one beat is in flight on the rank at a time
      if (i_done) begin
        done_d[s] = done_q[s] | (issued_q[s] & ~done_q[s]);
      end
      if (accept && alloc_oh[s]) begin
        valid_d[s]  = 1'b1;
        seq_d[s]    = live_cnt;
        issued_d[s] = '0;
        for (int b = 0; b < MaxBurstLen; b++) begin
          done_d[s][b]    = b > int'(i_len);
          present_d[s][b] = !TracksData || b > int'(i_len) || b < int'(i_data_cnt);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      release_q <= '0;
      for (int s = 0; s < NumSlots; s++) begin
        seq_q[s]     <= '0;
        present_q[s] <= '0;
        issued_q[s]  <= '0;
        done_q[s]    <= '0;
      end
    end else begin
      valid_q   <= valid_d;
      release_q <= release_d;
      seq_q     <= seq_d;
      present_q <= present_d;
      issued_q  <= issued_d;
      done_q    <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NumSlots; s++) begin
      if (accept && alloc_oh[s]) begin
        iid_q[s]  <= i_iid;
        base_q[s] <= i_addr;
        size_q[s] <= i_size;
      end
    end
  end

  assign o_release_en = release_q;

endmodule

// ==== delay_calc_assertions.sv ====
`timescale 1ns/1ps

module delay_calc_assertions #(
  parameter int unsigned WIidWidth = 3,
  parameter int unsigned RIidWidth = 3
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic                                  i_cmd_valid,
  input  logic [delay_calc_pkg::DelayWidth-1:0] i_cmd_delay,
  input  logic                                  i_done,
  input  logic                                  i_w_sel,
  input  logic [2**WIidWidth-1:0]               i_wresp_release_en,
  input  logic [2**RIidWidth-1:0]               i_rdata_release_en,
  input  logic                                  i_waddr_ready,
  input  logic                                  i_raddr_ready,
  input  logic                                  i_wdata_ready
);

  import delay_calc_pkg::*;

  logic [DelayWidth-1:0] gap_q;

  // Cycles left before the rank may take another command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gap_q <= '0;
    end else if (i_cmd_valid) begin
      gap_q <= i_cmd_delay - 1'b1;
    end else if (gap_q != '0) begin
      gap_q <= gap_q - 1'b1;
    end
  end

  cmd_spacing_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_cmd_valid |-> gap_q == '0)
    else $error("command issued with %0d cycles of the last delay left", gap_q);

  // A release bit rises two cycles after the final done of its direction
  w_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i_wresp_release_en & ~$past(i_wresp_release_en)) != '0 |-> $past(i_done && i_w_sel, 2))
    else $error("write release bit rose without a completed burst");

  r_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i_rdata_release_en & ~$past(i_rdata_release_en)) != '0 |-> $past(i_done && !i_w_sel, 2))
    else $error("read release bit rose without a completed burst");

  ready_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({i_waddr_ready, i_raddr_ready, i_wdata_ready}))
    else $error("ready output is unknown");

endmodule

bind delay_calc_top delay_calc_assertions #(
  .WIidWidth(WIidWidth),
  .RIidWidth(RIidWidth)
) u_delay_calc_assertions (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .i_cmd_valid       (o_cmd_valid),
  .i_cmd_delay       (o_cmd_delay),
  .i_done            (done),
  .i_w_sel           (w_sel),
  .i_wresp_release_en(o_wresp_release_en),
  .i_rdata_release_en(o_rdata_release_en),
  .i_waddr_ready     (o_waddr_ready),
  .i_raddr_ready     (o_raddr_ready),
  .i_wdata_ready     (o_wdata_ready)
);

// ==== delay_calc_pkg.sv ====
package delay_calc_pkg;

  // Memory byte address
  localparam int unsigned AddrWidth = 20;

  // Burst length field holds the number of beats minus one
  localparam int unsigned BurstLenWidth = 3;
  localparam int unsigned MaxBurstLen = 8;

  // Log2 of the bytes carried by one beat
  localparam int unsigned BurstSizeWidth = 2;

  // Low address bits that fall inside one row buffer
  localparam int unsigned RowBufferLenWidth = 8;

  // Rank delay counter, wide enough for the largest beat cost
  localparam int unsigned DelayWidth = 5;

  // Beat costs in cycles
  localparam int unsigned RowHitCost = 4;
  localparam int unsigned ActivationCost = 6;
  localparam int unsigned PrechargeCost = 5;

  // Row buffer outcome of one beat, expanded to cycles by the cost model
  typedef enum logic [1:0] {
    cost_hit    = 2'd0,
    cost_closed = 2'd1,
    cost_miss   = 2'd2
  } cost_e;

endpackage

// ==== delay_calc_top.sv ====
`timescale 1ns/1ps

module delay_calc_top #(
  parameter int unsigned NumWSlots = 4,
  parameter int unsigned NumRSlots = 4,
  parameter int unsigned WIidWidth = 3,
  parameter int unsigned RIidWidth = 3
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Write address
  input  logic                                      i_waddr_valid,
  output logic                                      o_waddr_ready,
  input  logic [WIidWidth-1:0]                      i_waddr_iid,
  input  logic [delay_calc_pkg::AddrWidth-1:0]      i_waddr_addr,
  input  logic [delay_calc_pkg::BurstLenWidth-1:0]  i_waddr_len,
  input  logic [delay_calc_pkg::BurstSizeWidth-1:0] i_waddr_size,
  input  logic [delay_calc_pkg::BurstLenWidth:0]    i_waddr_data_cnt,

  // Write data
  input  logic i_wdata_valid,
  output logic o_wdata_ready,

  // Read address
  input  logic                                      i_raddr_valid,
  output logic                                      o_raddr_ready,
  input  logic [RIidWidth-1:0]                      i_raddr_iid,
  input  logic [delay_calc_pkg::AddrWidth-1:0]      i_raddr_addr,
  input  logic [delay_calc_pkg::BurstLenWidth-1:0]  i_raddr_len,
  input  logic [delay_calc_pkg::BurstSizeWidth-1:0] i_raddr_size,

  // Release enables and feedback from the response banks
  output logic [2**WIidWidth-1:0] o_wresp_release_en,
  output logic [2**RIidWidth-1:0] o_rdata_release_en,
  input  logic [2**WIidWidth-1:0] i_wresp_released_onehot,
  input  logic [2**RIidWidth-1:0] i_rdata_released_onehot,

  // Memory command stream
  output logic                                  o_cmd_valid,
  output logic                                  o_cmd_is_write,
  output logic [delay_calc_pkg::AddrWidth-1:0]  o_cmd_addr,
  output logic [delay_calc_pkg::DelayWidth-1:0] o_cmd_delay
);

  import delay_calc_pkg::*;

  logic                  w_cand_valid;
  logic                  r_cand_valid;
  logic [AddrWidth-1:0]  w_cand_addr;
  logic [AddrWidth-1:0]  r_cand_addr;
  logic [AddrWidth-1:0]  sel_addr;
  logic [DelayWidth-1:0] cost;
  logic                  w_sel;
  logic                  w_issue;
  logic                  r_issue;
  logic                  done;

  burst_slot_table #(
    .NumSlots  (NumWSlots),
    .iid_t     (logic [WIidWidth-1:0]),
    .TracksData(1'b1)
  ) u_w_slots (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_valid          (i_waddr_valid),
    .o_ready          (o_waddr_ready),
    .i_iid            (i_waddr_iid),
    .i_addr           (i_waddr_addr),
    .i_len            (i_waddr_len),
    .i_size           (i_waddr_size),
    .i_data_cnt       (i_waddr_data_cnt),
    .i_data_valid     (i_wdata_valid),
    .o_data_ready     (o_wdata_ready),
    .o_cand_valid     (w_cand_valid),
    .o_cand_addr      (w_cand_addr),
    .i_issue          (w_issue),
    .i_done           (done && w_sel),
    .o_release_en     (o_wresp_release_en),
    .i_released_onehot(i_wresp_released_onehot)
  );

  // Read bursts carry no data on this side
  burst_slot_table #(
    .NumSlots  (NumRSlots),
    .iid_t     (logic [RIidWidth-1:0]),
    .TracksData(1'b0)
  ) u_r_slots (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_valid          (i_raddr_valid),
    .o_ready          (o_raddr_ready),
    .i_iid            (i_raddr_iid),
    .i_addr           (i_raddr_addr),
    .i_len            (i_raddr_len),
    .i_size           (i_raddr_size),
    .i_data_cnt       ('0),
    .i_data_valid     (1'b0),
    .o_data_ready     (),
    .o_cand_valid     (r_cand_valid),
    .o_cand_addr      (r_cand_addr),
    .i_issue          (r_issue),
    .i_done           (done && !w_sel),
    .o_release_en     (o_rdata_release_en),
    .i_released_onehot(i_rdata_released_onehot)
  );

  assign sel_addr = w_sel ? w_cand_addr : r_cand_addr;

  row_cost_model u_row_cost_model (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .i_addr(sel_addr),
    .i_open(o_cmd_valid),
    .o_cost(cost)
  );

  rank_scheduler u_rank_scheduler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_w_cand_valid(w_cand_valid),
    .i_r_cand_valid(r_cand_valid),
    .i_cost        (cost),
    .o_w_sel       (w_sel),
    .o_w_issue     (w_issue),
    .o_r_issue     (r_issue),
    .o_done        (done),
    .o_cmd_delay   (o_cmd_delay)
  );

  assign o_cmd_valid    = w_issue || r_issue;
  assign o_cmd_is_write = w_issue;
  assign o_cmd_addr     = sel_addr;

endmodule

// ==== project.f ====
delay_calc_pkg.sv
burst_slot_table.sv
row_cost_model.sv
rank_scheduler.sv
delay_calc_top.sv
delay_calc_assertions.sv
tb_delay_calc.sv

// ==== rank_scheduler.sv ====
`timescale 1ns/1ps

module rank_scheduler (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic                                  i_w_cand_valid,
  input  logic                                  i_r_cand_valid,
  input  logic [delay_calc_pkg::DelayWidth-1:0] i_cost,

  output logic                                  o_w_sel,
  output logic                                  o_w_issue,
  output logic                                  o_r_issue,
  output logic                                  o_done,
  output logic [delay_calc_pkg::DelayWidth-1:0] o_cmd_delay
);

  import delay_calc_pkg::*;

  logic [DelayWidth-1:0] cnt_q;
  logic [DelayWidth-1:0] cnt_d;
  logic                  inflight_w_q;
  logic                  idle;
  logic                  issue;

  assign idle = (cnt_q == '0);

  // Writes go first whenever both directions have a beat ready
  assign o_w_issue = idle && i_w_cand_valid;
  assign o_r_issue = idle && !i_w_cand_valid && i_r_cand_valid;
  assign issue     = o_w_issue || o_r_issue;

  // While busy the select follows the beat in flight so done reaches its table
  assign o_w_sel = idle ? i_w_cand_valid : inflight_w_q;

  // Last cycle of the current beat
  assign o_done = (cnt_q == DelayWidth'(1));

  // Cycles until the rank can take the next command
  assign o_cmd_delay = idle ? i_cost : cnt_q;

  // Loading cost minus one puts the next issue exactly cost cycles later
  always_comb begin
    if (!idle) begin
      cnt_d = cnt_q - 1'b1;
    end else if (issue) begin
      cnt_d = i_cost - 1'b1;
    end else begin
      cnt_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      inflight_w_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      if (issue) begin
        inflight_w_q <= o_w_issue;
      end
    end
  end

endmodule

// ==== row_cost_model.sv ====
`timescale 1ns/1ps

module row_cost_model (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic [delay_calc_pkg::AddrWidth-1:0]  i_addr,
  input  logic                                  i_open,
  output logic [delay_calc_pkg::DelayWidth-1:0] o_cost
);

  import delay_calc_pkg::*;

  localparam int unsigned RowWidth = AddrWidth - RowBufferLenWidth;

  logic                row_open_q;
  logic [RowWidth-1:0] open_row_q;
  logic [RowWidth-1:0] addr_row;
  cost_e               cost_class;

  assign addr_row = i_addr[AddrWidth-1:RowBufferLenWidth];

  // Classify the beat against the row buffer
  always_comb begin
    if (!row_open_q) begin
      cost_class = cost_closed;
    end else if (addr_row == open_row_q) begin
      cost_class = cost_hit;
    end else begin
      cost_class = cost_miss;
    end
  end

  always_comb begin
    case (cost_class)
      cost_hit:    o_cost = DelayWidth'(RowHitCost);
      cost_closed: o_cost = DelayWidth'(RowHitCost + ActivationCost);
      default:     o_cost = DelayWidth'(RowHitCost + ActivationCost + PrechargeCost);
    endcase
  end

  // Row stays open once any command has been issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_open_q <= 1'b0;
    end else if (i_open) begin
      row_open_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (i_open) begin
      open_row_q <= addr_row;
    end
  end

endmodule

// ==== tb_delay_calc.sv ====
`timescale 1ns/1ps

module tb_delay_calc;

  import delay_calc_pkg::*;

  localparam int NumWSlots = 4;
  localparam int NumRSlots = 4;
  localparam int WIidWidth = 3;
  localparam int RIidWidth = 3;
  localparam int Entries = 5;
  localparam int Timeout = 200;
  localparam int RowWidth = AddrWidth - RowBufferLenWidth;

  logic clk_i;
  logic rst_ni;
  logic waddr_valid;
  logic waddr_ready;
  logic [WIidWidth-1:0] waddr_iid;
  logic [AddrWidth-1:0] waddr_addr;
  logic [BurstLenWidth-1:0] waddr_len;
  logic [BurstSizeWidth-1:0] waddr_size;
  logic [BurstLenWidth:0] waddr_data_cnt;
  logic wdata_valid;
  logic wdata_ready;
  logic raddr_valid;
  logic raddr_ready;
  logic [RIidWidth-1:0] raddr_iid;
  logic [AddrWidth-1:0] raddr_addr;
  logic [BurstLenWidth-1:0] raddr_len;
  logic [BurstSizeWidth-1:0] raddr_size;
  logic [2**WIidWidth-1:0] wresp_release_en;
  logic [2**RIidWidth-1:0] rdata_release_en;
  logic [2**WIidWidth-1:0] wresp_released_onehot;
  logic [2**RIidWidth-1:0] rdata_released_onehot;
  logic cmd_valid;
  logic cmd_is_write;
  logic [AddrWidth-1:0] cmd_addr;
  logic [DelayWidth-1:0] cmd_delay;

  // Bursts; pair launches an entry in the same cycle as the next one
  // first is the expected delay of the burst's first command
  logic tbl_write [Entries] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  logic [2:0] tbl_iid [Entries] = '{3'd2, 3'd5, 3'd1, 3'd3, 3'd6};
  logic [AddrWidth-1:0] tbl_addr [Entries] = '{20'h01200, 20'h01240, 20'h3a000,
                                               20'h3a100, 20'h3a180};
  logic [BurstLenWidth-1:0] tbl_len [Entries] = '{3'd3, 3'd2, 3'd1, 3'd1, 3'd0};
  logic [BurstSizeWidth-1:0] tbl_size [Entries] = '{2'd2, 2'd3, 2'd1, 2'd2, 2'd0};
  logic [BurstLenWidth:0] tbl_dcnt [Entries] = '{4'd0, 4'd0, 4'd0, 4'd2, 4'd0};
  logic tbl_pair [Entries] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  int tbl_first [Entries] = '{10, 4, 15, 15, 4};

  // Reference model state
  logic exp_wr_q [$];
  logic [AddrWidth-1:0] exp_addr_q [$];
  int exp_delay_q [$];
  logic ref_open;
  logic [RowWidth-1:0] ref_row;

  integer seed;
  int cmd_cnt;
  int check_cnt;
  int val_errs;
  int other_errs;

  delay_calc_top #(
    .NumWSlots(NumWSlots),
    .NumRSlots(NumRSlots),
    .WIidWidth(WIidWidth),
    .RIidWidth(RIidWidth)
  ) u_delay_calc_top (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .i_waddr_valid          (waddr_valid),
    .o_waddr_ready          (waddr_ready),
    .i_waddr_iid            (waddr_iid),
    .i_waddr_addr           (waddr_addr),
    .i_waddr_len            (waddr_len),
    .i_waddr_size           (waddr_size),
    .i_waddr_data_cnt       (waddr_data_cnt),
    .i_wdata_valid          (wdata_valid),
    .o_wdata_ready          (wdata_ready),
    .i_raddr_valid          (raddr_valid),
    .o_raddr_ready          (raddr_ready),
    .i_raddr_iid            (raddr_iid),
    .i_raddr_addr           (raddr_addr),
    .i_raddr_len            (raddr_len),
    .i_raddr_size           (raddr_size),
    .o_wresp_release_en     (wresp_release_en),
    .o_rdata_release_en     (rdata_release_en),
    .i_wresp_released_onehot(wresp_released_onehot),
    .i_rdata_released_onehot(rdata_released_onehot),
    .o_cmd_valid            (cmd_valid),
    .o_cmd_is_write         (cmd_is_write),
    .o_cmd_addr             (cmd_addr),
    .o_cmd_delay            (cmd_delay)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_timeout(input int t, input string what);
    check_cnt++;
    assert (t < Timeout) else begin
      $display("timed out waiting for %s", what);
      other_errs++;
    end
  endtask

  // Expected commands of one burst, costed against the open row
  task automatic push_burst(input logic wr, input logic [AddrWidth-1:0] base,
                            input logic [BurstLenWidth-1:0] len,
                            input logic [BurstSizeWidth-1:0] size, input int first);
    logic [AddrWidth-1:0] a;
    logic [RowWidth-1:0] row;
    int cost;
    for (int b = 0; b <= int'(len); b++) begin
      a = base + (AddrWidth'(b) << size);
      row = a[AddrWidth-1:RowBufferLenWidth];
      if (!ref_open) begin
        cost = RowHitCost + ActivationCost;
      end else if (row == ref_row) begin
        cost = RowHitCost;
      end else begin
        cost = RowHitCost + ActivationCost + PrechargeCost;
      end
      if (b == 0 && first != 0) begin
        cost = first;
      end
      ref_open = 1'b1;
      ref_row = row;
      exp_wr_q.push_back(wr);
      exp_addr_q.push_back(a);
      exp_delay_q.push_back(cost);
    end
  endtask

  task automatic set_burst(input logic wr, input logic [2:0] iid,
                           input logic [AddrWidth-1:0] addr,
                           input logic [BurstLenWidth-1:0] len,
                           input logic [BurstSizeWidth-1:0] size,
                           input logic [BurstLenWidth:0] dcnt);
    if (wr) begin
      waddr_valid = 1'b1;
      waddr_iid = iid;
      waddr_addr = addr;
      waddr_len = len;
      waddr_size = size;
      waddr_data_cnt = dcnt;
    end else begin
      raddr_valid = 1'b1;
      raddr_iid = iid;
      raddr_addr = addr;
      raddr_len = len;
      raddr_size = size;
    end
  endtask

  // Hold the driven bursts until every one of them meets ready
  task automatic wait_accept();
    int t;
    t = 0;
    @(negedge clk_i);
    while (!((!waddr_valid || waddr_ready) && (!raddr_valid || raddr_ready)) &&
           t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    check_timeout(t, "address handshake");
    @(posedge clk_i);
    #1;
    waddr_valid = 1'b0;
    raddr_valid = 1'b0;
  endtask

  task automatic send_wdata(input int beats);
    int gap;
    int t;
    for (int n = 0; n < beats; n++) begin
      gap = {$random(seed)} % 4;
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
      wdata_valid = 1'b1;
      t = 0;
      @(negedge clk_i);
      while (!wdata_ready && t < Timeout) begin
        @(negedge clk_i);
        t++;
      end
      check_timeout(t, "write data handshake");
      @(posedge clk_i);
      #1;
      wdata_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_addr_q.size() != 0 && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    check_timeout(t, "expected commands");
    exp_wr_q.delete();
    exp_addr_q.delete();
    exp_delay_q.delete();
    @(posedge clk_i);
    #1;
  endtask

  // Wait for the release bit, answer with a released pulse, see it fall
  task automatic release_iid(input logic wr, input int iid);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!(wr ? wresp_release_en[iid] : rdata_release_en[iid]) && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    check_timeout(t, "release bit");
    @(posedge clk_i);
    #1;
    if (wr) begin
      wresp_released_onehot[iid] = 1'b1;
    end else begin
      rdata_released_onehot[iid] = 1'b1;
    end
    @(posedge clk_i);
    #1;
    wresp_released_onehot = '0;
    rdata_released_onehot = '0;
    @(negedge clk_i);
    if (wr) begin
      check_value("o_wresp_release_en", 32'(wresp_release_en[iid]), 0);
    end else begin
      check_value("o_rdata_release_en", 32'(rdata_release_en[iid]), 0);
    end
    @(posedge clk_i);
    #1;
  endtask

  // Command monitor against the reference queue
  always @(negedge clk_i) begin
    if (rst_ni && cmd_valid) begin
      cmd_cnt++;
      check_cnt++;
      assert (exp_addr_q.size() != 0) else begin
        $display("command at address %h came when none was expected", cmd_addr);
        other_errs++;
      end
      if (exp_addr_q.size() != 0) begin
        check_value("o_cmd_is_write", 32'(cmd_is_write), 32'(exp_wr_q.pop_front()));
        check_value("o_cmd_addr", 32'(cmd_addr), 32'(exp_addr_q.pop_front()));
        check_value("o_cmd_delay", 32'(cmd_delay), 32'(exp_delay_q.pop_front()));
      end
    end
  end

  initial begin
    int i;
    int n;
    int seen;
    int t;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    seed = 47;
    cmd_cnt = 0;
    check_cnt = 0;
    val_errs = 0;
    other_errs = 0;
    ref_open = 1'b0;
    ref_row = '0;
    waddr_valid = 1'b0;
    waddr_iid = '0;
    waddr_addr = '0;
    waddr_len = '0;
    waddr_size = '0;
    waddr_data_cnt = '0;
    wdata_valid = 1'b0;
    raddr_valid = 1'b0;
    raddr_iid = '0;
    raddr_addr = '0;
    raddr_len = '0;
    raddr_size = '0;
    wresp_released_onehot = '0;
    rdata_released_onehot = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_value("o_waddr_ready", 32'(waddr_ready), 1);
    check_value("o_raddr_ready", 32'(raddr_ready), 1);
    check_value("o_wdata_ready", 32'(wdata_ready), 0);
    check_value("o_wresp_release_en", 32'(wresp_release_en), 0);
    check_value("o_rdata_release_en", 32'(rdata_release_en), 0);
    check_value("o_cmd_valid", 32'(cmd_valid), 0);
    @(posedge clk_i);
    #1;

    i = 0;
    while (i < Entries) begin
      n = tbl_pair[i] ? 2 : 1;
      for (int k = i; k < i + n; k++) begin
        push_burst(tbl_write[k], tbl_addr[k], tbl_len[k], tbl_size[k], tbl_first[k]);
        set_burst(tbl_write[k], tbl_iid[k], tbl_addr[k], tbl_len[k], tbl_size[k],
                  tbl_dcnt[k]);
      end
      wait_accept();
      for (int k = i; k < i + n; k++) begin
        if (tbl_write[k] && tbl_dcnt[k] == 0) begin
          // Nothing may issue while the write burst has no data
          seen = cmd_cnt;
          repeat (8) @(posedge clk_i);
          #1;
          check_cnt++;
          assert (cmd_cnt == seen) else begin
            $display("a command issued before any write data arrived");
            other_errs++;
          end
        end
        if (tbl_write[k]) begin
          send_wdata(int'(tbl_len[k]) + 1 - int'(tbl_dcnt[k]));
        end
      end
      wait_drain();
      for (int k = i; k < i + n; k++) begin
        release_iid(tbl_write[k], int'(tbl_iid[k]));
      end
      i = i + n;
    end

    // Back-pressure with every write slot waiting for data
    for (int s = 0; s < NumWSlots; s++) begin
      push_burst(1'b1, AddrWidth'(32'h05000 + s * 16), '0, '0, 0);
      set_burst(1'b1, 3'(s), AddrWidth'(32'h05000 + s * 16), '0, '0, '0);
      wait_accept();
    end
    @(negedge clk_i);
    check_value("o_waddr_ready", 32'(waddr_ready), 0);
    @(posedge clk_i);
    #1;
    send_wdata(1);
    t = 0;
    @(negedge clk_i);
    while (!waddr_ready && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    check_timeout(t, "write address ready to return");
    @(posedge clk_i);
    #1;
    send_wdata(NumWSlots - 1);
    wait_drain();
    for (int s = 0; s < NumWSlots; s++) begin
      release_iid(1'b1, s);
    end

    $display("checks %0d, value errors %0d, other errors %0d",
             check_cnt, val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
